// ==== include/ofdm_cfg_defs.svh ====
`ifndef OFDM_CFG_DEFS_SVH
`define OFDM_CFG_DEFS_SVH

// wishbone slave geometry
`define OFDM_WB_AW 4                   // byte address bits
`define OFDM_WB_DW 32                  // data bus width

// register map, byte addresses
`define OFDM_REG_CTRL   4'h0           // bw code, carrier enable, update strobe
`define OFDM_REG_STATUS 4'h4           // applied bw, sticky done
`define OFDM_REG_PARAMS 4'h8           // subcarrier count, fft size

// bit positions inside the registers
`define OFDM_CTRL_EN_BIT  4            // carrier enable
`define OFDM_CTRL_UPD_BIT 8            // update strobe, write only
`define OFDM_STAT_DONE_BIT 8           // sticky done, write 1 to clear

// fft stage scaling schedules, 2 bits per stage, last stage first
`define OFDM_SCALE_NORMAL 12'b00_01_01_01_01_10
`define OFDM_SCALE_5MHZ   12'b00_00_01_01_01_10

// fft sizes as log2
`define OFDM_NFFT_2048 5'd11
`define OFDM_NFFT_1024 5'd10
`define OFDM_NFFT_512  5'd9

// occupied subcarriers per bandwidth
`define OFDM_NSCS_20MHZ 16'd1200
`define OFDM_NSCS_15MHZ 16'd900
`define OFDM_NSCS_10MHZ 16'd600
`define OFDM_NSCS_5MHZ  16'd300

`endif

// ==== hw/ofdm_cfg_pkg.sv ====
`default_nettype none

package ofdm_cfg_pkg;

    // channel bandwidth code as written by the host
    typedef logic [3:0] ch_bw_t;

    // log2 of the fft size
    typedef logic [4:0] nfft_t;

    // number of occupied subcarriers
    typedef logic [15:0] nscs_t;

    // scaling schedule, 2 bits per butterfly stage
    typedef logic [11:0] scale_t;

    // control word for the fft core
    typedef struct packed {
        logic   fwd_inv;               // 1 = forward fft, 0 = inverse
        scale_t scale_sch;
    } fft_ctrl_t;

    // bandwidth codes, anything else decodes like 20 MHz
    localparam ch_bw_t BW_20MHZ = 4'd0;
    localparam ch_bw_t BW_10MHZ = 4'd1;
    localparam ch_bw_t BW_5MHZ  = 4'd2;
    localparam ch_bw_t BW_15MHZ = 4'd3;

    // reconfiguration sequencer states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_NFFT_WE = 2'd1,
        ST_CTRL_WE = 2'd2
    } upd_state_t;

endpackage

`default_nettype wire

// ==== hw/cfg_regs_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_cfg_defs.svh"

module cfg_regs_wb
    import ofdm_cfg_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire logic [`OFDM_WB_AW-1:0] wb_adr,
    input  wire logic [`OFDM_WB_DW-1:0] wb_dat_w,
    input  wire logic [3:0]             wb_sel,        // byte lanes ignored, full words only
    output logic      [`OFDM_WB_DW-1:0] wb_dat_r,
    output logic                        wb_ack,
    output ch_bw_t                      ch_bw,
    output logic                        car_en,
    output logic                        update_req,
    input  wire ch_bw_t                 current_ch_bw,
    input  wire nscs_t                  nscs,
    input  wire nfft_t                  nfft_size,
    input  wire logic                   update_done
);

    logic                   bus_req;
    logic                   wr_en;
    logic                   done_flag;
    logic [`OFDM_WB_DW-1:0] rd_data;

    assign bus_req = wb_cyc & wb_stb & ~wb_ack;    // no second ack while the first is out
    assign wr_en   = bus_req & wb_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req;                     // one cycle after cyc & stb
        end
    end

    // CTRL register and the update strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            ch_bw      <= '0;
            car_en     <= 1'b0;
            update_req <= 1'b0;
        end else begin
            update_req <= 1'b0;
            if (wr_en && wb_adr == `OFDM_REG_CTRL) begin
                ch_bw      <= wb_dat_w[3:0];
                car_en     <= wb_dat_w[`OFDM_CTRL_EN_BIT];
                update_req <= wb_dat_w[`OFDM_CTRL_UPD_BIT];
            end
        end
    end

    // sticky done, a new completion wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            done_flag <= 1'b0;
        end else if (update_done) begin
            done_flag <= 1'b1;
        end else if (wr_en && wb_adr == `OFDM_REG_STATUS
                     && wb_dat_w[`OFDM_STAT_DONE_BIT]) begin
            done_flag <= 1'b0;
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `OFDM_REG_CTRL: begin
                rd_data[3:0]             = ch_bw;
                rd_data[`OFDM_CTRL_EN_BIT] = car_en;   // strobe bit reads 0
            end
            `OFDM_REG_STATUS: begin
                rd_data[3:0]                 = current_ch_bw;
                rd_data[`OFDM_STAT_DONE_BIT] = done_flag;
            end
            `OFDM_REG_PARAMS: begin
                rd_data[15:0]  = nscs;
                rd_data[20:16] = nfft_size;
            end
            default: rd_data = '0;                 // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus_req) begin
            wb_dat_r <= rd_data;                   // valid together with ack
        end
    end

endmodule

`default_nettype wire

// ==== hw/bw_update.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_cfg_defs.svh"

module bw_update
    import ofdm_cfg_pkg::*;
#(
    parameter int FFT_IFFT = 1                     // 1 = fft, 0 = ifft
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       car_en,
    input  wire logic       update_req,
    input  wire ch_bw_t     ch_bw,
    input  wire logic [1:0] stage_busy,            // {ctrl, nfft}
    output nfft_t           nfft_size,
    output nscs_t           nscs,
    output fft_ctrl_t       ctrl_word,
    output logic            nfft_we,
    output logic            ctrl_we,
    output ch_bw_t          current_ch_bw,
    output logic            update_done
);

    upd_state_t state;
    logic       car_en_d;
    logic       pending;
    logic       new_req;
    logic       start;
    ch_bw_t     bw_lat;                            // code captured at start

    assign new_req = (car_en & ~car_en_d) | update_req;
    assign start   = (state == ST_IDLE) & (new_req | pending) & ~|stage_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            car_en_d <= 1'b0;
            pending  <= 1'b0;
        end else begin
            car_en_d <= car_en;
            pending  <= (pending | new_req) & ~start;  // back-to-back triggers merge
        end
    end

    // decode on start so the words and PARAMS match the applied code
    always_ff @(posedge clk) begin
        if (start) begin
            bw_lat <= ch_bw;
            case (ch_bw)
                BW_10MHZ: begin
                    nfft_size <= `OFDM_NFFT_1024;
                    nscs      <= `OFDM_NSCS_10MHZ;
                end
                BW_5MHZ: begin
                    nfft_size <= `OFDM_NFFT_512;
                    nscs      <= `OFDM_NSCS_5MHZ;
                end
                BW_15MHZ: begin
                    nfft_size <= `OFDM_NFFT_2048;
                    nscs      <= `OFDM_NSCS_15MHZ;
                end
                default: begin                     // 20 MHz and unknown codes
                    nfft_size <= `OFDM_NFFT_2048;
                    nscs      <= `OFDM_NSCS_20MHZ;
                end
            endcase
            ctrl_word.fwd_inv <= (FFT_IFFT != 0);
            if (FFT_IFFT != 0 && ch_bw == BW_5MHZ) begin
                ctrl_word.scale_sch <= `OFDM_SCALE_5MHZ;   // less headroom for the 512 point fft
            end else begin
                ctrl_word.scale_sch <= `OFDM_SCALE_NORMAL;
            end
        end
    end

    // idle -> nfft_we -> ctrl_we, done one cycle after ctrl_we
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            nfft_we       <= 1'b0;
            ctrl_we       <= 1'b0;
            update_done   <= 1'b0;
            current_ch_bw <= '0;
        end else begin
            nfft_we     <= start;
            ctrl_we     <= (state == ST_NFFT_WE);
            update_done <= (state == ST_CTRL_WE);
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_NFFT_WE;
                    end
                end
                ST_NFFT_WE: begin
                    state         <= ST_CTRL_WE;
                    current_ch_bw <= bw_lat;       // visible with ctrl_we
                end
                ST_CTRL_WE: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/cfg_hold.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_hold #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     load,
    input  wire payload_t load_data,
    output logic          valid,
    input  wire logic     ready,
    output payload_t      data,
    output logic          busy
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;                         // offered from the next cycle
        end else if (valid && ready) begin
            valid <= 1'b0;                         // word taken by the fft core
        end
    end

    // data only moves on load, so it stays put until the transfer
    always_ff @(posedge clk) begin
        if (load) begin
            data <= load_data;
        end
    end

    // sequencer holds off new loads while a word is waiting
    assign busy = valid;

endmodule

`default_nettype wire

// ==== hw/ofdm_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_cfg_defs.svh"

module ofdm_cfg_top
    import ofdm_cfg_pkg::*;
#(
    parameter int FFT_IFFT = 1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire logic [`OFDM_WB_AW-1:0] wb_adr,
    input  wire logic [`OFDM_WB_DW-1:0] wb_dat_w,
    input  wire logic [3:0]             wb_sel,
    output logic      [`OFDM_WB_DW-1:0] wb_dat_r,
    output logic                        wb_ack,
    output logic                        nfft_valid,
    input  wire logic                   nfft_ready,
    output nfft_t                       nfft_data,
    output logic                        ctrl_valid,
    input  wire logic                   ctrl_ready,
    output fft_ctrl_t                   ctrl_data
);

    ch_bw_t    ch_bw;
    logic      car_en;
    logic      update_req;
    ch_bw_t    current_ch_bw;
    nscs_t     nscs;
    nfft_t     nfft_size;
    fft_ctrl_t ctrl_word;
    logic      update_done;
    logic      nfft_we;
    logic      ctrl_we;
    logic      nfft_busy;
    logic      ctrl_busy;

    cfg_regs_wb cfg_regs_wb_inst (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_sel        (wb_sel),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .ch_bw         (ch_bw),
        .car_en        (car_en),
        .update_req    (update_req),
        .current_ch_bw (current_ch_bw),
        .nscs          (nscs),
        .nfft_size     (nfft_size),
        .update_done   (update_done)
    );

    bw_update #(
        .FFT_IFFT (FFT_IFFT)
    ) bw_update_inst (
        .clk           (clk),
        .reset         (reset),
        .car_en        (car_en),
        .update_req    (update_req),
        .ch_bw         (ch_bw),
        .stage_busy    ({ctrl_busy, nfft_busy}),
        .nfft_size     (nfft_size),
        .nscs          (nscs),
        .ctrl_word     (ctrl_word),
        .nfft_we       (nfft_we),
        .ctrl_we       (ctrl_we),
        .current_ch_bw (current_ch_bw),
        .update_done   (update_done)
    );

    cfg_hold #(
        .payload_t (nfft_t)
    ) nfft_hold (
        .clk       (clk),
        .reset     (reset),
        .load      (nfft_we),
        .load_data (nfft_size),
        .valid     (nfft_valid),
        .ready     (nfft_ready),
        .data      (nfft_data),
        .busy      (nfft_busy)
    );

    cfg_hold #(
        .payload_t (fft_ctrl_t)
    ) ctrl_hold (
        .clk       (clk),
        .reset     (reset),
        .load      (ctrl_we),
        .load_data (ctrl_word),
        .valid     (ctrl_valid),
        .ready     (ctrl_ready),
        .data      (ctrl_data),
        .busy      (ctrl_busy)
    );

endmodule

`default_nettype wire

// ==== bench/ofdm_cfg_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ofdm_cfg_checker
    import ofdm_cfg_pkg::*;
(
    input wire logic      clk,
    input wire logic      reset,
    input wire logic      wb_ack,
    input wire logic      nfft_we,
    input wire logic      ctrl_we,
    input wire logic      update_done,
    input wire logic      nfft_valid,
    input wire logic      nfft_ready,
    input wire nfft_t     nfft_data,
    input wire logic      ctrl_valid,
    input wire logic      ctrl_ready,
    input wire fft_ctrl_t ctrl_data
);

    // sequencer order, nfft_we then ctrl_we then done
    a_ctrl_after_nfft: assert property (@(posedge clk) disable iff (reset)
        nfft_we |=> ctrl_we)
        else $error("ctrl_we did not follow nfft_we by one cycle");

    a_done_after_ctrl: assert property (@(posedge clk) disable iff (reset)
        ctrl_we |=> update_done)
        else $error("update_done did not follow ctrl_we by one cycle");

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

    // an offered word must not move or vanish before the core takes it
    a_nfft_hold: assert property (@(posedge clk) disable iff (reset)
        nfft_valid && !nfft_ready |=> nfft_valid && $stable(nfft_data))
        else $error("nfft word changed or dropped before transfer");

    a_ctrl_hold: assert property (@(posedge clk) disable iff (reset)
        ctrl_valid && !ctrl_ready |=> ctrl_valid && $stable(ctrl_data))
        else $error("ctrl word changed or dropped before transfer");

endmodule

bind ofdm_cfg_top ofdm_cfg_checker checker_inst (
    .clk         (clk),
    .reset       (reset),
    .wb_ack      (wb_ack),
    .nfft_we     (nfft_we),
    .ctrl_we     (ctrl_we),
    .update_done (update_done),
    .nfft_valid  (nfft_valid),
    .nfft_ready  (nfft_ready),
    .nfft_data   (nfft_data),
    .ctrl_valid  (ctrl_valid),
    .ctrl_ready  (ctrl_ready),
    .ctrl_data   (ctrl_data)
);

`default_nettype wire

// ==== bench/ofdm_cfg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_cfg_defs.svh"

module ofdm_cfg_tb
    import ofdm_cfg_pkg::*;
;

    localparam int FFT_MODE = 1;
    localparam int NUM_ROWS = 7;

    logic                   clk;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`OFDM_WB_AW-1:0] wb_adr;
    logic [31:0]            wb_dat_w;
    logic [3:0]             wb_sel;
    logic [31:0]            wb_dat_r;
    logic                   wb_ack;
    logic                   nfft_valid;
    logic                   nfft_ready;
    nfft_t                  nfft_data;
    logic                   ctrl_valid;
    logic                   ctrl_ready;
    fft_ctrl_t              ctrl_data;

    integer    seed;
    nfft_t     nfft_got[$];                        // words taken on the fft port
    fft_ctrl_t ctrl_got[$];

    // stimulus table with expected columns from the decode rules
    ch_bw_t    row_bw     [NUM_ROWS];
    logic      row_strobe [NUM_ROWS];              // 1 = update strobe, 0 = enable edge
    int        row_stall  [NUM_ROWS];
    nfft_t     row_nfft   [NUM_ROWS];
    nscs_t     row_nscs   [NUM_ROWS];
    fft_ctrl_t row_ctrl   [NUM_ROWS];

    ofdm_cfg_top #(
        .FFT_IFFT (FFT_MODE)
    ) ofdm_cfg_top_inst (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .nfft_valid (nfft_valid),
        .nfft_ready (nfft_ready),
        .nfft_data  (nfft_data),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready),
        .ctrl_data  (ctrl_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (!reset) begin
            if (nfft_valid && nfft_ready) nfft_got.push_back(nfft_data);
            if (ctrl_valid && ctrl_ready) ctrl_got.push_back(ctrl_data);
        end
    end

    function automatic nfft_t exp_nfft(input ch_bw_t code);
        case (code)
            4'd1:    return 5'd10;                 // 1024 point
            4'd2:    return 5'd9;                  // 512 point
            default: return 5'd11;                 // 2048 point for 20, 15 and unknown
        endcase
    endfunction

    function automatic nscs_t exp_nscs(input ch_bw_t code);
        case (code)
            4'd1:    return 16'd600;
            4'd2:    return 16'd300;
            4'd3:    return 16'd900;
            default: return 16'd1200;
        endcase
    endfunction

    function automatic fft_ctrl_t exp_ctrl(input ch_bw_t code);
        fft_ctrl_t c;
        c.fwd_inv   = (FFT_MODE != 0);
        c.scale_sch = (FFT_MODE != 0 && code == 4'd2) ? `OFDM_SCALE_5MHZ : `OFDM_SCALE_NORMAL;
        return c;
    endfunction

    function automatic logic [31:0] ctrl_value(input ch_bw_t code, input logic en,
                                               input logic upd);
        logic [31:0] v;
        v    = '0;
        v[3:0] = code;
        v[4] = en;
        v[8] = upd;
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "mismatch");
    endtask

    task automatic check_nfft(input nfft_t got, input nfft_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_ctrl(input fft_ctrl_t got, input fft_ctrl_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %h expected %h", what, got, exp));
    endtask

    task automatic check_nscs(input nscs_t got, input nscs_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_bw(input ch_bw_t got, input ch_bw_t exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) report_mismatch($sformatf("%s: got %h expected %h", what, got, exp));
    endtask

    task automatic bus_cycle(input logic we, input logic [`OFDM_WB_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do @(negedge clk); while (!wb_ack);       // hold the cycle until the slave acks
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [`OFDM_WB_AW-1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, wdat, unused_rd);
    endtask

    task automatic bus_read(input logic [`OFDM_WB_AW-1:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic wait_words(input int n);
        while (nfft_got.size() < n || ctrl_got.size() < n) @(negedge clk);
    endtask

    task automatic build_table();
        row_bw = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd2, 4'd3};
        row_strobe = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_stall[i] = $unsigned($random(seed)) % 8;
            row_nfft[i]  = exp_nfft(row_bw[i]);
            row_nscs[i]  = exp_nscs(row_bw[i]);
            row_ctrl[i]  = exp_ctrl(row_bw[i]);
        end
    endtask

    task automatic run_row(input int i);
        logic [31:0] rd;
        nfft_ready = 1'b0;
        ctrl_ready = 1'b0;
        nfft_got.delete();
        ctrl_got.delete();
        if (row_strobe[i]) begin
            bus_write(`OFDM_REG_CTRL, ctrl_value(row_bw[i], 1'b1, 1'b1));
        end else begin
            bus_write(`OFDM_REG_CTRL, ctrl_value(row_bw[i], 1'b0, 1'b0));
            bus_write(`OFDM_REG_CTRL, ctrl_value(row_bw[i], 1'b1, 1'b0));  // rising edge
        end
        repeat (row_stall[i]) @(negedge clk);
        nfft_ready = 1'b1;
        ctrl_ready = 1'b1;
        wait_words(1);
        do bus_read(`OFDM_REG_STATUS, rd); while (!rd[8]);
        check_bw(rd[3:0], row_bw[i], $sformatf("row %0d applied bw", i));
        bus_read(`OFDM_REG_PARAMS, rd);
        check_nscs(rd[15:0], row_nscs[i], $sformatf("row %0d PARAMS subcarriers", i));
        check_nfft(rd[20:16], row_nfft[i], $sformatf("row %0d PARAMS fft size", i));
        check_word(32'(nfft_got.size()), 32'd1, $sformatf("row %0d nfft word count", i));
        check_word(32'(ctrl_got.size()), 32'd1, $sformatf("row %0d ctrl word count", i));
        check_nfft(nfft_got[0], row_nfft[i], $sformatf("row %0d nfft word", i));
        check_ctrl(ctrl_got[0], row_ctrl[i], $sformatf("row %0d ctrl word", i));
        bus_write(`OFDM_REG_STATUS, 32'h0000_0100);   // write 1 clears done
        bus_read(`OFDM_REG_STATUS, rd);
        check_word(rd, {28'h0, row_bw[i]}, $sformatf("row %0d STATUS after clear", i));
    endtask

    task automatic check_backpressure();
        logic [31:0] rd;
        nfft_ready = 1'b0;
        ctrl_ready = 1'b0;
        nfft_got.delete();
        ctrl_got.delete();
        bus_write(`OFDM_REG_CTRL, ctrl_value(4'd0, 1'b1, 1'b1));
        while (!(nfft_valid && ctrl_valid)) @(negedge clk);
        bus_write(`OFDM_REG_CTRL, ctrl_value(4'd3, 1'b1, 1'b1));  // held as pending
        bus_write(`OFDM_REG_CTRL, ctrl_value(4'd2, 1'b1, 1'b1));  // merges with it
        repeat (8) @(negedge clk);
        check_nfft(nfft_data, exp_nfft(4'd0), "first nfft word while stalled");
        check_ctrl(ctrl_data, exp_ctrl(4'd0), "first ctrl word while stalled");
        nfft_ready = 1'b1;
        ctrl_ready = 1'b1;
        wait_words(2);
        repeat (10) @(negedge clk);                // no third pair may follow
        check_word(32'(nfft_got.size()), 32'd2, "nfft word count after stall");
        check_word(32'(ctrl_got.size()), 32'd2, "ctrl word count after stall");
        check_nfft(nfft_got[0], exp_nfft(4'd0), "nfft word before merge");
        check_ctrl(ctrl_got[0], exp_ctrl(4'd0), "ctrl word before merge");
        check_nfft(nfft_got[1], exp_nfft(4'd2), "nfft word after merge");
        check_ctrl(ctrl_got[1], exp_ctrl(4'd2), "ctrl word after merge");
        bus_read(`OFDM_REG_STATUS, rd);
        check_bw(rd[3:0], 4'd2, "applied bw after merge");
    endtask

    initial begin
        repeat (NUM_ROWS * 200) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", NUM_ROWS * 200);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rd;
        seed       = 32'h2fe1_9476;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = 4'hf;
        nfft_ready = 1'b0;
        ctrl_ready = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        reset = 1'b0;

        bus_read(`OFDM_REG_STATUS, rd);
        check_word(rd, 32'h0, "STATUS after reset");
        bus_read(`OFDM_REG_CTRL, rd);
        check_word(rd, 32'h0, "CTRL after reset");
        check_word({30'h0, nfft_valid, ctrl_valid}, 32'h0, "valids after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        check_backpressure();

        // enable stays high and a new code alone must stay quiet
        nfft_got.delete();
        ctrl_got.delete();
        bus_write(`OFDM_REG_CTRL, ctrl_value(4'd1, 1'b1, 1'b0));
        repeat (12) @(negedge clk);
        check_word(32'(nfft_got.size() + ctrl_got.size()), 32'd0, "words without trigger");
        bus_read(`OFDM_REG_STATUS, rd);
        check_bw(rd[3:0], 4'd2, "applied bw without trigger");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hw/ofdm_cfg_pkg.sv
hw/cfg_regs_wb.sv
hw/bw_update.sv
hw/cfg_hold.sv
hw/ofdm_cfg_top.sv
bench/ofdm_cfg_checker.sv
bench/ofdm_cfg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ofdm_cfg_tb -f flist.f -o ofdm_cfg_sim \
    && ./obj_dir/ofdm_cfg_sim \
    || { echo "simulation failed"; exit 1; }
